//--- src/cpu_pkg.sv
package cpu_pkg;

    // operations kept in this core
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_LD   = 4'd1,
        OP_ADD  = 4'd2,
        OP_SUB  = 4'd3,
        OP_AND  = 4'd4,
        OP_OR   = 4'd5,
        OP_XOR  = 4'd6,
        OP_EX   = 4'd7,
        OP_INCF = 4'd8,
        OP_DECF = 4'd9,
        OP_LDF  = 4'd10
    } opcode_e;

    // operand width
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_WORD = 2'd1,
        SZ_LONG = 2'd2
    } size_e;

    // flag bit positions in the low byte of sr
    localparam int FLAG_C = 0;
    localparam int FLAG_V = 2;
    localparam int FLAG_Z = 6;
    localparam int FLAG_S = 7;

    // status register word
    // high byte carries rfp in bits 9:8 and reads zero elsewhere
    typedef logic [15:0] sr_t;

    localparam int SR_RFP_LSB = 8;

    localparam sr_t SR_RESET = 16'h0000;

endpackage

//--- src/regs_pkg.sv
package regs_pkg;

    // register selector
    // bank bytes at 0x00-0x3f, pointer bytes at 0x80-0x8f
    typedef logic [7:0] reg_code_t;

    // one byte as seen on the dump port
    typedef logic [7:0] reg_byte_t;

    // register file pointer
    typedef logic [1:0] rfp_t;

    // high nibble aliases resolved against rfp
    localparam logic [3:0] CUR_BANK  = 4'hE;
    localparam logic [3:0] PREV_BANK = 4'hD;

    localparam int BANK_BYTES = 64;
    localparam int PTR_BYTES  = 16;

    // XSP lives in pointer bytes 12..15
    localparam int          XSP_BYTE  = 12;
    localparam logic [31:0] XSP_RESET = 32'h0000_0100;

    // dump address map
    localparam logic [7:0] DMP_PTR_BASE = 8'h40;
    localparam logic [7:0] DMP_SR_HI    = 8'h50;
    localparam logic [7:0] DMP_SR_LO    = 8'h51;

endpackage

//--- src/cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               op_valid,
    input  cpu_pkg::opcode_e   opcode,
    input  cpu_pkg::size_e     op_size,
    input  regs_pkg::reg_code_t op_dst,
    input  regs_pkg::reg_code_t op_src,
    input  logic [31:0]        op_imm,
    input  logic               src_imm,
    output logic               ex_valid,
    output cpu_pkg::opcode_e   alu_op,
    output cpu_pkg::size_e     ex_size,
    output logic [31:0]        ex_imm,
    output logic               use_imm,
    output regs_pkg::reg_code_t src_sel,
    output regs_pkg::reg_code_t dst_sel,
    output logic [2:0]         we,
    output logic               ex_we,
    output logic               flag_we,
    output logic               inc_rfp,
    output logic               dec_rfp,
    output logic               rfp_we
);

    logic       accept;
    logic       valid_d;
    logic [2:0] we_d;
    logic       ex_we_d;
    logic       flag_we_d;
    logic       inc_d;
    logic       dec_d;
    logic       ldf_d;
    logic [2:0] size_we;

    assign accept = cen && op_valid;

    // one-hot byte/word/long enable
    always_comb begin
        case (op_size)
            cpu_pkg::SZ_BYTE: size_we = 3'b001;
            cpu_pkg::SZ_WORD: size_we = 3'b010;
            cpu_pkg::SZ_LONG: size_we = 3'b100;
            default:          size_we = 3'b000;
        endcase
    end

    always_comb begin
        valid_d   = op_valid && (opcode != cpu_pkg::OP_NOP);
        we_d      = 3'b000;
        ex_we_d   = 1'b0;
        flag_we_d = 1'b0;
        inc_d     = 1'b0;
        dec_d     = 1'b0;
        ldf_d     = 1'b0;
        if (op_valid) begin
            case (opcode)
                cpu_pkg::OP_LD: we_d = size_we;
                cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
                cpu_pkg::OP_OR, cpu_pkg::OP_XOR: begin
                    we_d      = size_we;
                    flag_we_d = 1'b1;
                end
                cpu_pkg::OP_EX: begin
                    we_d    = size_we;
                    ex_we_d = 1'b1;
                end
                cpu_pkg::OP_INCF: inc_d = 1'b1;
                cpu_pkg::OP_DECF: dec_d = 1'b1;
                cpu_pkg::OP_LDF:  ldf_d = 1'b1;
                default: ;
            endcase
        end
    end

    // control strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid <= 1'b0;
            we       <= 3'b000;
            ex_we    <= 1'b0;
            flag_we  <= 1'b0;
            inc_rfp  <= 1'b0;
            dec_rfp  <= 1'b0;
            rfp_we   <= 1'b0;
        end else if (cen) begin
            ex_valid <= valid_d;
            we       <= we_d;
            ex_we    <= ex_we_d;
            flag_we  <= flag_we_d;
            inc_rfp  <= inc_d;
            dec_rfp  <= dec_d;
            rfp_we   <= ldf_d;
        end
    end

    // operands and immediate of the accepted instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            alu_op  <= opcode;
            ex_size <= op_size;
            ex_imm  <= op_imm;
            // EX always swaps two registers
            use_imm <= src_imm && (opcode != cpu_pkg::OP_EX);
            src_sel <= op_src;
            dst_sel <= op_dst;
        end
    end

endmodule

//--- src/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  logic             ex_valid,
    input  cpu_pkg::opcode_e alu_op,
    input  cpu_pkg::size_e   ex_size,
    input  logic             use_imm,
    input  logic [31:0]      ex_imm,
    input  logic [31:0]      src_out,
    input  logic [31:0]      dst_out,
    input  logic             flag_we,
    input  regs_pkg::rfp_t   rfp,
    output logic [31:0]      alu_dout,
    output cpu_pkg::sr_t     sr
);

    logic [31:0] opnd;
    logic [31:0] b_eff;
    logic [31:0] res;
    logic [32:0] sum;
    logic [32:0] cvec;
    logic        is_sub;
    logic        is_arith;
    logic [5:0]  msb;
    logic        zero;
    logic [7:0]  flags_d;
    logic [7:0]  flags_q;

    assign opnd     = use_imm ? ex_imm : src_out;
    assign is_sub   = (alu_op == cpu_pkg::OP_SUB);
    assign is_arith = is_sub || (alu_op == cpu_pkg::OP_ADD);

    // subtraction as dst + ~opnd + 1
    assign b_eff = is_sub ? ~opnd : opnd;
    assign sum   = {1'b0, dst_out} + {1'b0, b_eff} + {32'd0, is_sub};
    // carry into every bit position
    assign cvec  = {1'b0, dst_out} ^ {1'b0, b_eff} ^ sum;

    always_comb begin
        case (alu_op)
            cpu_pkg::OP_ADD,
            cpu_pkg::OP_SUB: res = sum[31:0];
            cpu_pkg::OP_AND: res = dst_out & opnd;
            cpu_pkg::OP_OR:  res = dst_out | opnd;
            cpu_pkg::OP_XOR: res = dst_out ^ opnd;
            default:         res = opnd;
        endcase
    end

    assign alu_dout = res;

    always_comb begin
        case (ex_size)
            cpu_pkg::SZ_BYTE: begin
                msb  = 6'd7;
                zero = (res[7:0] == 8'd0);
            end
            cpu_pkg::SZ_WORD: begin
                msb  = 6'd15;
                zero = (res[15:0] == 16'd0);
            end
            default: begin
                msb  = 6'd31;
                zero = (res == 32'd0);
            end
        endcase
    end

    always_comb begin
        flags_d = 8'd0;
        flags_d[cpu_pkg::FLAG_Z] = zero;
        flags_d[cpu_pkg::FLAG_S] = res[msb[4:0]];
        if (is_arith) begin
            // borrow is the inverted carry on SUB
            flags_d[cpu_pkg::FLAG_C] = cvec[msb + 6'd1] ^ is_sub;
            flags_d[cpu_pkg::FLAG_V] = cvec[msb] ^ cvec[msb + 6'd1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags_q <= cpu_pkg::SR_RESET[7:0];
        end else if (cen && ex_valid && flag_we) begin
            flags_q <= flags_d;
        end
    end

    always_comb begin
        sr = cpu_pkg::SR_RESET;
        sr[cpu_pkg::SR_RFP_LSB +: 2] = rfp;
        sr[7:0] = flags_q;
    end

endmodule

//--- src/cpu_regs.sv
`timescale 1ns/1ps

module cpu_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  regs_pkg::reg_code_t src_sel,
    input  regs_pkg::reg_code_t dst_sel,
    input  logic [2:0]          we,
    input  logic                ex_we,
    input  logic [31:0]         alu_dout,
    input  logic                inc_rfp,
    input  logic                dec_rfp,
    input  logic                rfp_we,
    input  logic [1:0]          ex_imm,
    input  cpu_pkg::sr_t        sr,
    input  logic [7:0]          dmp_addr,
    output logic [31:0]         src_out,
    output logic [31:0]         dst_out,
    output regs_pkg::rfp_t      rfp,
    output regs_pkg::reg_byte_t dmp_dout
);

    regs_pkg::reg_byte_t bank [0:regs_pkg::BANK_BYTES-1];
    regs_pkg::reg_byte_t ptr  [0:regs_pkg::PTR_BYTES-1];

    regs_pkg::reg_code_t src_a;
    regs_pkg::reg_code_t dst_a;
    logic [3:0]          byte_en;

    // resolve current/previous bank aliases
    function automatic regs_pkg::reg_code_t translate(
        input regs_pkg::reg_code_t code,
        input regs_pkg::rfp_t      cur
    );
        regs_pkg::reg_code_t r;
        r = code;
        if (code[7:4] == regs_pkg::CUR_BANK) begin
            r[7:4] = {2'b00, cur};
        end else if (code[7:4] == regs_pkg::PREV_BANK) begin
            r[7:4] = {2'b00, cur - 2'd1};
        end
        return r;
    endfunction

    // word and long accesses start on their natural boundary
    function automatic regs_pkg::reg_code_t align(
        input regs_pkg::reg_code_t code,
        input logic [2:0]          size_we
    );
        regs_pkg::reg_code_t r;
        r = code;
        if (size_we[1]) begin
            r[0] = 1'b0;
        end
        if (size_we[2]) begin
            r[1:0] = 2'b00;
        end
        return r;
    endfunction

    // four bytes from the code upwards in little-endian order
    function automatic logic [31:0] read4(input regs_pkg::reg_code_t code);
        logic [31:0] v;
        if (code[7]) begin
            v = {ptr[{code[3:2], 2'b11}], ptr[{code[3:2], 2'b10}],
                 ptr[{code[3:1], 1'b1}], ptr[code[3:0]]};
        end else begin
            v = {bank[{code[5:2], 2'b11}], bank[{code[5:2], 2'b10}],
                 bank[{code[5:1], 1'b1}], bank[code[5:0]]};
        end
        return v;
    endfunction

    assign src_a = align(translate(src_sel, rfp), we);
    assign dst_a = align(translate(dst_sel, rfp), we);

    always_comb begin
        src_out = read4(src_a);
        dst_out = read4(dst_a);
    end

    always_comb begin
        case (1'b1)
            we[2]:   byte_en = 4'b1111;
            we[1]:   byte_en = 4'b0011;
            we[0]:   byte_en = 4'b0001;
            default: byte_en = 4'b0000;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < regs_pkg::BANK_BYTES; i++) begin
                bank[i] <= 8'd0;
            end
            for (int i = 0; i < regs_pkg::XSP_BYTE; i++) begin
                ptr[i] <= 8'd0;
            end
            for (int i = 0; i < 4; i++) begin
                ptr[regs_pkg::XSP_BYTE + i] <= regs_pkg::XSP_RESET[8*i +: 8];
            end
        end else if (cen) begin
            for (int k = 0; k < 4; k++) begin
                if (byte_en[k]) begin
                    // result into destination
                    if (dst_a[7]) begin
                        ptr[{dst_a[3:2], dst_a[1:0] | 2'(k)}] <= alu_dout[8*k +: 8];
                    end else begin
                        bank[{dst_a[5:2], dst_a[1:0] | 2'(k)}] <= alu_dout[8*k +: 8];
                    end
                    // old destination back into source for EX
                    if (ex_we) begin
                        if (src_a[7]) begin
                            ptr[{src_a[3:2], src_a[1:0] | 2'(k)}] <= dst_out[8*k +: 8];
                        end else begin
                            bank[{src_a[5:2], src_a[1:0] | 2'(k)}] <= dst_out[8*k +: 8];
                        end
                    end
                end
            end
        end
    end

    // bank pointer with LDF ahead of inc and dec
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfp <= 2'd0;
        end else if (cen) begin
            if (rfp_we) begin
                rfp <= ex_imm;
            end else if (inc_rfp) begin
                rfp <= rfp + 2'd1;
            end else if (dec_rfp) begin
                rfp <= rfp - 2'd1;
            end
        end
    end

    // dump keeps running with cen low
    always_ff @(posedge clk) begin
        if (dmp_addr < regs_pkg::DMP_PTR_BASE) begin
            dmp_dout <= bank[dmp_addr[5:0]];
        end else if (dmp_addr < regs_pkg::DMP_SR_HI) begin
            dmp_dout <= ptr[dmp_addr[3:0]];
        end else if (dmp_addr == regs_pkg::DMP_SR_HI) begin
            dmp_dout <= sr[15:8];
        end else if (dmp_addr == regs_pkg::DMP_SR_LO) begin
            dmp_dout <= sr[7:0];
        end else begin
            dmp_dout <= 8'd0;
        end
    end

endmodule

//--- src/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                op_valid,
    input  cpu_pkg::opcode_e    opcode,
    input  cpu_pkg::size_e      op_size,
    input  regs_pkg::reg_code_t op_dst,
    input  regs_pkg::reg_code_t op_src,
    input  logic [31:0]         op_imm,
    input  logic                src_imm,
    input  logic [7:0]          dmp_addr,
    output regs_pkg::reg_byte_t dmp_dout,
    output regs_pkg::rfp_t      rfp
);

    // decode to execute
    logic                ex_valid;
    cpu_pkg::opcode_e    alu_op;
    cpu_pkg::size_e      ex_size;
    logic [31:0]         ex_imm;
    logic                use_imm;
    regs_pkg::reg_code_t src_sel;
    regs_pkg::reg_code_t dst_sel;
    logic [2:0]          we;
    logic                ex_we;
    logic                flag_we;
    logic                inc_rfp;
    logic                dec_rfp;
    logic                rfp_we;

    // operands and result
    logic [31:0]         src_out;
    logic [31:0]         dst_out;
    logic [31:0]         alu_dout;
    cpu_pkg::sr_t        sr;

    cpu_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .op_valid (op_valid),
        .opcode   (opcode),
        .op_size  (op_size),
        .op_dst   (op_dst),
        .op_src   (op_src),
        .op_imm   (op_imm),
        .src_imm  (src_imm),
        .ex_valid (ex_valid),
        .alu_op   (alu_op),
        .ex_size  (ex_size),
        .ex_imm   (ex_imm),
        .use_imm  (use_imm),
        .src_sel  (src_sel),
        .dst_sel  (dst_sel),
        .we       (we),
        .ex_we    (ex_we),
        .flag_we  (flag_we),
        .inc_rfp  (inc_rfp),
        .dec_rfp  (dec_rfp),
        .rfp_we   (rfp_we)
    );

    cpu_alu u_alu (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .ex_valid (ex_valid),
        .alu_op   (alu_op),
        .ex_size  (ex_size),
        .use_imm  (use_imm),
        .ex_imm   (ex_imm),
        .src_out  (src_out),
        .dst_out  (dst_out),
        .flag_we  (flag_we),
        .rfp      (rfp),
        .alu_dout (alu_dout),
        .sr       (sr)
    );

    cpu_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .src_sel  (src_sel),
        .dst_sel  (dst_sel),
        .we       (we),
        .ex_we    (ex_we),
        .alu_dout (alu_dout),
        .inc_rfp  (inc_rfp),
        .dec_rfp  (dec_rfp),
        .rfp_we   (rfp_we),
        .ex_imm   (ex_imm[1:0]),
        .sr       (sr),
        .dmp_addr (dmp_addr),
        .src_out  (src_out),
        .dst_out  (dst_out),
        .rfp      (rfp),
        .dmp_dout (dmp_dout)
    );

endmodule

//--- bench/tb_core.sv
`timescale 1ns/1ps

module tb_core;

    localparam int N_LD        = 200;
    localparam int N_BURSTS    = 30;
    localparam int BURST_LEN   = 10;
    localparam int N_BP        = 40;
    localparam int N_EX_SIZE   = 50;
    localparam int N_CEN       = 30;
    localparam int N_INSTR     = N_LD + N_BURSTS * BURST_LEN + 3 * N_BP
                               + 3 * N_EX_SIZE + 2 * N_CEN;
    localparam int WD_CYCLES   = 20 * N_INSTR + 1000;

    logic                clk;
    logic                rst;
    logic                cen;
    logic                op_valid;
    cpu_pkg::opcode_e    opcode;
    cpu_pkg::size_e      op_size;
    regs_pkg::reg_code_t op_dst;
    regs_pkg::reg_code_t op_src;
    logic [31:0]         op_imm;
    logic                src_imm;
    logic [7:0]          dmp_addr;
    regs_pkg::reg_byte_t dmp_dout;
    regs_pkg::rfp_t      rfp;

    // reference model
    // bytes 0..63 hold the banks and 64..79 the pointer bytes
    logic [7:0]     mem [0:79];
    regs_pkg::rfp_t m_rfp;
    logic [7:0]     m_flags;
    logic [7:0]     flag_q [$];

    int    n_tests;
    int    n_checks;
    int    n_errors;
    int    test_err_start;
    string test_name;

    // scratch for the test sequences
    cpu_pkg::opcode_e    xo, yo;
    cpu_pkg::size_e      xs, ys;
    regs_pkg::reg_code_t xd, xsrc, yd, ysrc;
    logic [31:0]         ximm, yimm;
    logic                xsi, ysi;
    regs_pkg::reg_byte_t b;
    regs_pkg::reg_byte_t v1, v2;
    logic [3:0]          n1, n2;
    regs_pkg::rfp_t      prev;
    cpu_pkg::sr_t        s;
    logic [7:0]          exp_f;
    int                  base;

    cpu_core u_dut (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .op_valid (op_valid),
        .opcode   (opcode),
        .op_size  (op_size),
        .op_dst   (op_dst),
        .op_src   (op_src),
        .op_imm   (op_imm),
        .src_imm  (src_imm),
        .dmp_addr (dmp_addr),
        .dmp_dout (dmp_dout),
        .rfp      (rfp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int size_bytes(input cpu_pkg::size_e sz);
        if (sz == cpu_pkg::SZ_BYTE) return 1;
        if (sz == cpu_pkg::SZ_WORD) return 2;
        return 4;
    endfunction

    // model byte index of a register code, aligned down to the width
    function automatic int addr_of(input regs_pkg::reg_code_t code, input int nb);
        int             a;
        regs_pkg::rfp_t pb;
        pb = m_rfp - 2'd1;
        if (code[7:4] == regs_pkg::CUR_BANK) a = int'(m_rfp) * 16 + int'(code[3:0]);
        else if (code[7:4] == regs_pkg::PREV_BANK) a = int'(pb) * 16 + int'(code[3:0]);
        else if (code[7]) a = 64 + int'(code[3:0]);
        else a = int'(code[5:0]);
        return a - (a % nb);
    endfunction

    function automatic logic [31:0] read_model(input int a, input int nb);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < nb; i++) v[8*i +: 8] = mem[a + i];
        return v;
    endfunction

    function automatic void write_model(input int a, input int nb, input logic [31:0] v);
        for (int i = 0; i < nb; i++) mem[a + i] = v[8*i +: 8];
    endfunction

    function automatic void apply_model(input cpu_pkg::opcode_e op, input cpu_pkg::size_e sz,
                                        input regs_pkg::reg_code_t dst,
                                        input regs_pkg::reg_code_t src,
                                        input logic [31:0] imm, input logic simm);
        int          nb;
        int          w;
        int          da;
        int          sa;
        logic [31:0] mask;
        logic [31:0] dv;
        logic [31:0] sv;
        logic [31:0] r;
        logic [32:0] full;
        logic        c;
        logic        v;
        nb   = size_bytes(sz);
        w    = 8 * nb;
        mask = (nb == 4) ? 32'hFFFF_FFFF : ((32'd1 << w) - 32'd1);
        da   = addr_of(dst, nb);
        sa   = addr_of(src, nb);
        dv   = read_model(da, nb);
        sv   = (simm && op != cpu_pkg::OP_EX) ? (imm & mask) : read_model(sa, nb);
        c    = 1'b0;
        v    = 1'b0;
        r    = 32'd0;
        case (op)
            cpu_pkg::OP_LD:   write_model(da, nb, sv);
            cpu_pkg::OP_EX: begin
                write_model(da, nb, sv);
                write_model(sa, nb, dv);
            end
            cpu_pkg::OP_INCF: m_rfp = m_rfp + 2'd1;
            cpu_pkg::OP_DECF: m_rfp = m_rfp - 2'd1;
            cpu_pkg::OP_LDF:  m_rfp = imm[1:0];
            cpu_pkg::OP_NOP:  ;
            default: begin
                if (op == cpu_pkg::OP_ADD) begin
                    full = {1'b0, dv} + {1'b0, sv};
                    r    = full[31:0] & mask;
                    c    = full[w];
                    v    = (dv[w-1] == sv[w-1]) && (r[w-1] != dv[w-1]);
                end else if (op == cpu_pkg::OP_SUB) begin
                    r = (dv - sv) & mask;
                    c = dv < sv;
                    v = (dv[w-1] != sv[w-1]) && (r[w-1] != dv[w-1]);
                end else if (op == cpu_pkg::OP_AND) r = dv & sv;
                else if (op == cpu_pkg::OP_OR) r = dv | sv;
                else r = dv ^ sv;
                write_model(da, nb, r);
                m_flags = 8'd0;
                m_flags[cpu_pkg::FLAG_C] = c;
                m_flags[cpu_pkg::FLAG_V] = v;
                m_flags[cpu_pkg::FLAG_Z] = (r == 32'd0);
                m_flags[cpu_pkg::FLAG_S] = r[w-1];
            end
        endcase
    endfunction

    function automatic cpu_pkg::sr_t expected_sr();
        cpu_pkg::sr_t e;
        e = cpu_pkg::SR_RESET;
        e[9:8] = m_rfp;
        e[7:0] = m_flags;
        return e;
    endfunction

    function automatic regs_pkg::reg_code_t random_code();
        logic [3:0]          n;
        regs_pkg::reg_code_t c;
        n = 4'($urandom_range(0, 15));
        case ($urandom_range(0, 3))
            0: c = 8'($urandom_range(0, 63));
            1: c = {4'h8, n};
            2: c = {regs_pkg::CUR_BANK, n};
            default: c = {regs_pkg::PREV_BANK, n};
        endcase
        return c;
    endfunction

    function automatic cpu_pkg::size_e random_size();
        case ($urandom_range(0, 2))
            0: return cpu_pkg::SZ_BYTE;
            1: return cpu_pkg::SZ_WORD;
            default: return cpu_pkg::SZ_LONG;
        endcase
    endfunction

    function automatic cpu_pkg::opcode_e random_alu_op();
        case ($urandom_range(0, 4))
            0: return cpu_pkg::OP_ADD;
            1: return cpu_pkg::OP_SUB;
            2: return cpu_pkg::OP_AND;
            3: return cpu_pkg::OP_OR;
            default: return cpu_pkg::OP_XOR;
        endcase
    endfunction

    function automatic cpu_pkg::opcode_e random_any_op();
        case ($urandom_range(0, 3))
            0: return cpu_pkg::OP_LD;
            1: return random_alu_op();
            2: return cpu_pkg::OP_INCF;
            default: return ($urandom_range(0, 1) == 0) ? cpu_pkg::OP_DECF : cpu_pkg::OP_LDF;
        endcase
    endfunction

    task automatic check_byte(input regs_pkg::reg_byte_t got, input regs_pkg::reg_byte_t exp,
                              input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL @ %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_flags(input cpu_pkg::sr_t got, input cpu_pkg::sr_t exp,
                               input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL @ %0t: %s got %04h expected %04h", $time, what, got, exp);
        end
    endtask

    task automatic check_rfp(input regs_pkg::rfp_t got, input regs_pkg::rfp_t exp,
                             input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL @ %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // all drive tasks start and end on a falling edge
    task automatic drive(input cpu_pkg::opcode_e op, input cpu_pkg::size_e sz,
                         input regs_pkg::reg_code_t dst, input regs_pkg::reg_code_t src,
                         input logic [31:0] imm, input logic simm);
        op_valid = 1'b1;
        opcode   = op;
        op_size  = sz;
        op_dst   = dst;
        op_src   = src;
        op_imm   = imm;
        src_imm  = simm;
    endtask

    task automatic issue(input cpu_pkg::opcode_e op, input cpu_pkg::size_e sz,
                         input regs_pkg::reg_code_t dst, input regs_pkg::reg_code_t src,
                         input logic [31:0] imm, input logic simm);
        drive(op, sz, dst, src, imm, simm);
        apply_model(op, sz, dst, src, imm, simm);
        @(posedge clk);
        @(negedge clk);
    endtask

    // last instruction leaves execute on the next edge
    task automatic drain();
        op_valid = 1'b0;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic read_dump(input logic [7:0] a, output regs_pkg::reg_byte_t d);
        dmp_addr = a;
        @(posedge clk);
        @(negedge clk);
        d = dmp_dout;
    endtask

    task automatic read_sr(output cpu_pkg::sr_t v);
        regs_pkg::reg_byte_t hi;
        regs_pkg::reg_byte_t lo;
        read_dump(regs_pkg::DMP_SR_HI, hi);
        read_dump(regs_pkg::DMP_SR_LO, lo);
        v = {hi, lo};
    endtask

    task automatic dump_all();
        regs_pkg::reg_byte_t d;
        for (int a = 0; a < 80; a++) begin
            read_dump(8'(a), d);
            check_byte(d, mem[a], $sformatf("dump byte %02h", a));
        end
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = n_errors;
        n_tests++;
    endtask

    task automatic end_test();
        $display("test %s %s (%0d errors)", test_name,
                 (n_errors == test_err_start) ? "ok" : "FAILED", n_errors - test_err_start);
    endtask

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WD_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(8));
        rst = 1'b1;
        cen = 1'b1;
        op_valid = 1'b0;
        opcode = cpu_pkg::OP_NOP;
        op_size = cpu_pkg::SZ_BYTE;
        op_dst = 8'd0;
        op_src = 8'd0;
        op_imm = 32'd0;
        src_imm = 1'b0;
        dmp_addr = 8'd0;
        n_tests = 0;
        n_checks = 0;
        n_errors = 0;
        for (int i = 0; i < 80; i++) mem[i] = 8'd0;
        // XSP resets to 0x100 in pointer bytes 12..15
        mem[77] = 8'h01;
        m_rfp = 2'd0;
        m_flags = 8'd0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test("reset");
        dump_all();
        read_sr(s);
        check_flags(s, 16'h0000, "sr after reset");
        check_rfp(rfp, 2'd0, "rfp after reset");
        end_test();

        begin_test("loads");
        for (int i = 0; i < N_LD; i++)
            issue(cpu_pkg::OP_LD, random_size(), random_code(), random_code(), $urandom,
                  1'($urandom_range(0, 1)));
        drain();
        dump_all();
        end_test();

        // flags reach the dump port three edges after the issue
        begin_test("alu");
        for (int k = 0; k < N_BURSTS; k++) begin
            dmp_addr = regs_pkg::DMP_SR_LO;
            flag_q.delete();
            for (int st = 0; st < BURST_LEN + 3; st++) begin
                if (st >= 3) begin
                    exp_f = flag_q.pop_front();
                    check_flags({8'h00, dmp_dout}, {8'h00, exp_f}, "flags after alu op");
                end
                if (st < BURST_LEN) begin
                    issue(random_alu_op(), random_size(), random_code(), random_code(),
                          $urandom, 1'($urandom_range(0, 1)));
                    flag_q.push_back(m_flags);
                end else begin
                    drain();
                end
            end
            dump_all();
        end
        end_test();

        begin_test("bank_ptr");
        for (int i = 0; i < N_BP; i++) begin
            case ($urandom_range(0, 2))
                0: xo = cpu_pkg::OP_INCF;
                1: xo = cpu_pkg::OP_DECF;
                default: xo = cpu_pkg::OP_LDF;
            endcase
            issue(xo, cpu_pkg::SZ_BYTE, 8'd0, 8'd0, $urandom, 1'b0);
            n1 = 4'($urandom_range(0, 15));
            n2 = 4'($urandom_range(0, 15));
            v1 = 8'($urandom_range(0, 255));
            v2 = 8'($urandom_range(0, 255));
            issue(cpu_pkg::OP_LD, cpu_pkg::SZ_BYTE, {regs_pkg::CUR_BANK, n1}, 8'd0,
                  {24'd0, v1}, 1'b1);
            issue(cpu_pkg::OP_LD, cpu_pkg::SZ_BYTE, {regs_pkg::PREV_BANK, n2}, 8'd0,
                  {24'd0, v2}, 1'b1);
            drain();
            check_rfp(rfp, m_rfp, "rfp output");
            read_sr(s);
            check_flags(s, expected_sr(), "sr with rfp");
            prev = m_rfp - 2'd1;
            read_dump({2'b00, m_rfp, n1}, b);
            check_byte(b, v1, "current bank load");
            read_dump({2'b00, prev, n2}, b);
            check_byte(b, v2, "previous bank load");
        end
        end_test();

        begin_test("exchange");
        for (int i = 0; i < 3 * N_EX_SIZE; i++) begin
            xs = (i < N_EX_SIZE) ? cpu_pkg::SZ_BYTE :
                 (i < 2 * N_EX_SIZE) ? cpu_pkg::SZ_WORD : cpu_pkg::SZ_LONG;
            xd = random_code();
            xsrc = random_code();
            issue(cpu_pkg::OP_EX, xs, xd, xsrc, $urandom, 1'b0);
            drain();
            // whole long word around each operand including bytes above the size
            base = addr_of(xd, 4);
            for (int j = 0; j < 4; j++) begin
                read_dump(8'(base + j), b);
                check_byte(b, mem[base + j], "ex destination");
            end
            base = addr_of(xsrc, 4);
            for (int j = 0; j < 4; j++) begin
                read_dump(8'(base + j), b);
                check_byte(b, mem[base + j], "ex source");
            end
        end
        end_test();

        begin_test("cen_hold");
        for (int i = 0; i < N_CEN; i++) begin
            xo = random_any_op();
            xs = random_size();
            xd = random_code();
            xsrc = random_code();
            ximm = $urandom;
            xsi = 1'($urandom_range(0, 1));
            yo = random_any_op();
            ys = random_size();
            yd = random_code();
            ysrc = random_code();
            yimm = $urandom;
            ysi = 1'($urandom_range(0, 1));
            drive(xo, xs, xd, xsrc, ximm, xsi);
            @(posedge clk);
            @(negedge clk);
            // x sits in decode while y waits on the inputs
            cen = 1'b0;
            drive(yo, ys, yd, ysrc, yimm, ysi);
            repeat ($urandom_range(1, 4)) begin
                @(posedge clk);
                @(negedge clk);
            end
            check_rfp(rfp, m_rfp, "rfp while cen low");
            read_sr(s);
            check_flags(s, expected_sr(), "sr while cen low");
            base = addr_of(xd, size_bytes(xs));
            for (int j = 0; j < size_bytes(xs); j++) begin
                read_dump(8'(base + j), b);
                check_byte(b, mem[base + j], "destination while cen low");
            end
            cen = 1'b1;
            apply_model(xo, xs, xd, xsrc, ximm, xsi);
            apply_model(yo, ys, yd, ysrc, yimm, ysi);
            @(posedge clk);
            @(negedge clk);
            drain();
        end
        dump_all();
        read_sr(s);
        check_flags(s, expected_sr(), "sr after cen test");
        check_rfp(rfp, m_rfp, "rfp after cen test");
        end_test();

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- all.f
src/cpu_pkg.sv
src/regs_pkg.sv
src/cpu_decode.sv
src/cpu_alu.sv
src/cpu_regs.sv
src/cpu_core.sv
bench/tb_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator

set -u
cd "$(dirname "$0")"

if ! verilator --binary --timing -j 0 -f all.f --top-module tb_core \
        -Mdir obj_dir -o sim_core; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_core)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Simulation passed$"; then
    exit 0
fi

echo "pass message not found"
exit 1
